//--- rtl/cannon_lasers.sv
`timescale 1ns/100ps

module cannon_lasers (
    input  logic                 clk25M,
    input  logic                 reset,
    input  invaders_pkg::phase_t phase,
    input  invaders_pkg::slot_t  slot,
    input  logic                 btn_left,
    input  logic                 btn_right,
    input  logic                 btn_fire,
    output invaders_pkg::coord_t cannon_h,
    output invaders_pkg::laser_t lasers [invaders_pkg::NUM_LASERS]
);

    logic [invaders_pkg::LASER_IDX_W-1:0] lidx;
    invaders_pkg::laser_t                 cur;
    logic [12:0]                          right_end;
    logic                                 fire_q;
    logic                                 spawned;

    assign lidx      = slot[invaders_pkg::LASER_IDX_W-1:0];
    assign cur       = lasers[lidx];
    assign right_end = {1'b0, cannon_h} +
                       13'(invaders_pkg::CANNON_SIZE + invaders_pkg::CANNON_STEP);

    always_ff @(posedge clk25M) begin
        if (reset) begin
            cannon_h <= invaders_pkg::coord_t'(invaders_pkg::CANNON_INIT_H);
            fire_q   <= 1'b0;
            spawned  <= 1'b0;
            for (int i = 0; i < invaders_pkg::NUM_LASERS; i++) begin
                lasers[i].active <= 1'b0;
            end
        end else if (phase == invaders_pkg::PH_CANNON) begin
            fire_q  <= btn_fire;
            spawned <= 1'b0;
            if (btn_left && cannon_h >= invaders_pkg::coord_t'(invaders_pkg::CANNON_STEP)) begin
                cannon_h <= cannon_h - invaders_pkg::coord_t'(invaders_pkg::CANNON_STEP);
            end else if (btn_right && right_end <= 13'(invaders_pkg::FIELD_WIDTH)) begin
                cannon_h <= cannon_h + invaders_pkg::coord_t'(invaders_pkg::CANNON_STEP);
            end
        end else if (phase == invaders_pkg::PH_LASERS) begin
            if (cur.active) begin
                // rise, or retire at the top
                if (cur.vpos >= invaders_pkg::coord_t'(invaders_pkg::LASER_STEP)) begin
                    lasers[lidx].vpos <= cur.vpos -
                        invaders_pkg::coord_t'(invaders_pkg::LASER_STEP);
                end else begin
                    lasers[lidx].active <= 1'b0;
                end
            end else if (fire_q && !spawned) begin
                lasers[lidx].active <= 1'b1;
                lasers[lidx].vpos   <= invaders_pkg::coord_t'(invaders_pkg::CANNON_V -
                                                             invaders_pkg::LASER_LEN);
                lasers[lidx].hpos   <= cannon_h +
                                       invaders_pkg::coord_t'(invaders_pkg::LASER_OFFSET_H);
                lasers[lidx].color  <= invaders_pkg::LASER_COLOR;
                spawned             <= 1'b1;
            end
        end
    end

endmodule

//--- rtl/first_hit_select.sv
`timescale 1ns/100ps

module first_hit_select #(
    parameter type entry_t     = logic,
    parameter int  NUM_ENTRIES = 1
) (
    input  logic [NUM_ENTRIES-1:0] hit,
    input  entry_t                 entries [NUM_ENTRIES],
    output logic                   any_hit,
    output entry_t                 chosen
);

    assign any_hit = |hit;

    // walk down so the lowest index wins
    always_comb begin
        chosen = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) chosen = entries[i];
        end
    end

endmodule

//--- rtl/invader_table.sv
`timescale 1ns/100ps

module invader_table (
    input  logic                   clk25M,
    input  logic                   reset,
    input  invaders_pkg::phase_t   phase,
    input  invaders_pkg::dir_t     dir,
    input  logic                   move_en,
    input  invaders_pkg::slot_t    slot,
    input  logic [3:0]             speed,
    output logic                   edge_hit,
    output invaders_pkg::invader_t invaders [invaders_pkg::NUM_INVADERS]
);

    invaders_pkg::invader_t cur;
    logic [12:0]            right_end;
    logic                   edge_now;
    logic                   edge_acc;

    assign cur       = invaders[slot];
    assign right_end = {1'b0, cur.hpos} + 13'(invaders_pkg::INVADER_SIZE) + 13'(speed);

    // edge test of the addressed slot
    always_comb begin
        edge_now = 1'b0;
        if (phase == invaders_pkg::PH_SCAN && cur.alive) begin
            case (dir)
                invaders_pkg::DIR_RIGHT:
                    edge_now = (right_end > 13'(invaders_pkg::FIELD_WIDTH));
                invaders_pkg::DIR_LEFT:
                    edge_now = (cur.hpos < invaders_pkg::coord_t'(speed));
                default:
                    edge_now = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk25M) begin
        if (reset || phase == invaders_pkg::PH_IDLE) begin
            edge_acc <= 1'b0;
        end else if (edge_now) begin
            edge_acc <= 1'b1;
        end
    end

    // includes the slot under test, so the last scan cycle counts
    assign edge_hit = edge_acc | edge_now;

    always_ff @(posedge clk25M) begin
        if (reset) begin
            for (int i = 0; i < invaders_pkg::NUM_INVADERS; i++) begin
                invaders[i] <= invaders_pkg::INVADER_INIT[i];
            end
        end else if (phase == invaders_pkg::PH_MOVE && move_en && cur.alive) begin
            case (dir)
                invaders_pkg::DIR_RIGHT:
                    invaders[slot].hpos <= cur.hpos + invaders_pkg::coord_t'(speed);
                invaders_pkg::DIR_LEFT:
                    invaders[slot].hpos <= cur.hpos - invaders_pkg::coord_t'(speed);
                default:
                    invaders[slot].vpos <= cur.vpos +
                        invaders_pkg::coord_t'(invaders_pkg::DOWN_STEP);
            endcase
        end
    end

endmodule

//--- rtl/invaders_pkg.sv
package invaders_pkg;

    typedef logic [11:0] coord_t;
    typedef logic [11:0] color_t;
    typedef logic [2:0]  slot_t;

    localparam int FIELD_WIDTH    = 640;
    localparam int NUM_INVADERS   = 8;
    localparam int NUM_LASERS     = 4;
    localparam int LASER_IDX_W    = $clog2(NUM_LASERS);
    localparam int INVADER_SIZE   = 32;
    localparam int CANNON_SIZE    = 32;
    localparam int CANNON_V       = 448;
    localparam int CANNON_STEP    = 2;
    localparam int CANNON_INIT_H  = 304;
    localparam int LASER_LEN      = 20;
    localparam int LASER_STEP     = 4;
    localparam int LASER_OFFSET_H = 16;
    localparam int DOWN_STEP      = 8;

    localparam color_t CANNON_COLOR = 12'hff0;
    localparam color_t LASER_COLOR  = 12'hfff;

    // alive | vpos | hpos | color
    typedef struct packed {
        logic   alive;
        coord_t vpos;
        coord_t hpos;
        color_t color;
    } invader_t;

    typedef struct packed {
        logic   active;
        coord_t vpos;
        coord_t hpos;
        color_t color;
    } laser_t;

    // two rows of four
    localparam invader_t INVADER_INIT [NUM_INVADERS] = '{
        '{1'b1, 12'd0,  12'd128, 12'hf00},
        '{1'b1, 12'd0,  12'd192, 12'h0f0},
        '{1'b1, 12'd0,  12'd256, 12'h00f},
        '{1'b1, 12'd0,  12'd320, 12'hf0f},
        '{1'b1, 12'd64, 12'd128, 12'h0ff},
        '{1'b1, 12'd64, 12'd192, 12'hf80},
        '{1'b1, 12'd64, 12'd256, 12'h8f0},
        '{1'b1, 12'd64, 12'd320, 12'h88f}
    };

    typedef enum logic [1:0] {
        DIR_RIGHT,
        DIR_DOWN,
        DIR_LEFT
    } dir_t;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_SCAN,
        PH_MOVE,
        PH_CANNON,
        PH_LASERS
    } phase_t;

    localparam int UPDATE_CYCLES = 2 * NUM_INVADERS + 1 + NUM_LASERS;

endpackage

//--- rtl/march_fsm.sv
`timescale 1ns/100ps

module march_fsm (
    input  logic                 clk25M,
    input  logic                 reset,
    input  logic                 frame_tick,
    input  logic                 march_en,
    input  logic                 last_slot,
    input  logic                 edge_hit,
    output invaders_pkg::phase_t phase,
    output invaders_pkg::dir_t   dir,
    output logic                 move_en,
    output logic                 update_busy
);

    invaders_pkg::dir_t last_h;
    logic               march_q;
    logic               edge_q;

    always_ff @(posedge clk25M) begin
        if (reset) begin
            phase <= invaders_pkg::PH_IDLE;
        end else begin
            case (phase)
                invaders_pkg::PH_IDLE: begin
                    if (frame_tick) phase <= invaders_pkg::PH_SCAN;
                end
                invaders_pkg::PH_SCAN: begin
                    if (last_slot) phase <= invaders_pkg::PH_MOVE;
                end
                invaders_pkg::PH_MOVE: begin
                    if (last_slot) phase <= invaders_pkg::PH_CANNON;
                end
                invaders_pkg::PH_CANNON: begin
                    if (last_slot) phase <= invaders_pkg::PH_LASERS;
                end
                invaders_pkg::PH_LASERS: begin
                    if (last_slot) phase <= invaders_pkg::PH_IDLE;
                end
                default: phase <= invaders_pkg::PH_IDLE;
            endcase
        end
    end

    // scan result and march enable held through the move phase
    always_ff @(posedge clk25M) begin
        if (reset) begin
            march_q <= 1'b0;
            edge_q  <= 1'b0;
            dir     <= invaders_pkg::DIR_RIGHT;
            last_h  <= invaders_pkg::DIR_RIGHT;
        end else if (phase == invaders_pkg::PH_SCAN && last_slot) begin
            march_q <= march_en;
            edge_q  <= edge_hit;
        end else if (phase == invaders_pkg::PH_MOVE && last_slot && march_q) begin
            if (dir == invaders_pkg::DIR_DOWN) begin
                // reverse after the step down
                dir <= (last_h == invaders_pkg::DIR_RIGHT) ? invaders_pkg::DIR_LEFT
                                                           : invaders_pkg::DIR_RIGHT;
            end else if (edge_q) begin
                last_h <= dir;
                dir    <= invaders_pkg::DIR_DOWN;
            end
        end
    end

    assign move_en     = march_q & ~edge_q;
    assign update_busy = (phase != invaders_pkg::PH_IDLE);

endmodule

//--- rtl/pixel_renderer.sv
`timescale 1ns/100ps

module pixel_renderer (
    input  logic                   clk25M,
    input  logic                   reset,
    input  invaders_pkg::coord_t   whpos,
    input  invaders_pkg::coord_t   wvpos,
    input  logic                   write_en,
    input  invaders_pkg::invader_t invaders [invaders_pkg::NUM_INVADERS],
    input  invaders_pkg::coord_t   cannon_h,
    input  invaders_pkg::laser_t   lasers [invaders_pkg::NUM_LASERS],
    output invaders_pkg::color_t   vdin
);

    logic [invaders_pkg::NUM_INVADERS-1:0] inv_hit;
    logic [invaders_pkg::NUM_LASERS-1:0]   las_hit;
    logic                                  cannon_hit;
    logic                                  inv_any;
    logic                                  las_any;
    invaders_pkg::invader_t                inv_pick;
    invaders_pkg::laser_t                  las_pick;
    logic [12:0]                           wh;
    logic [12:0]                           wv;

    // one extra bit so square ends never wrap
    assign wh = {1'b0, whpos};
    assign wv = {1'b0, wvpos};

    for (genvar i = 0; i < invaders_pkg::NUM_INVADERS; i++) begin : g_inv
        assign inv_hit[i] = invaders[i].alive
            && whpos >= invaders[i].hpos
            && wh < {1'b0, invaders[i].hpos} + 13'(invaders_pkg::INVADER_SIZE)
            && wvpos >= invaders[i].vpos
            && wv < {1'b0, invaders[i].vpos} + 13'(invaders_pkg::INVADER_SIZE);
    end

    // lasers are 3 pixels wide around hpos
    for (genvar i = 0; i < invaders_pkg::NUM_LASERS; i++) begin : g_las
        assign las_hit[i] = lasers[i].active
            && wh + 13'd1 >= {1'b0, lasers[i].hpos}
            && wh <= {1'b0, lasers[i].hpos} + 13'd1
            && wvpos >= lasers[i].vpos
            && wv < {1'b0, lasers[i].vpos} + 13'(invaders_pkg::LASER_LEN);
    end

    assign cannon_hit = whpos >= cannon_h
        && wh < {1'b0, cannon_h} + 13'(invaders_pkg::CANNON_SIZE)
        && wv >= 13'(invaders_pkg::CANNON_V)
        && wv < 13'(invaders_pkg::CANNON_V + invaders_pkg::CANNON_SIZE);

    first_hit_select #(
        .entry_t     (invaders_pkg::invader_t),
        .NUM_ENTRIES (invaders_pkg::NUM_INVADERS)
    ) i_inv_pick (
        .hit     (inv_hit),
        .entries (invaders),
        .any_hit (inv_any),
        .chosen  (inv_pick)
    );

    first_hit_select #(
        .entry_t     (invaders_pkg::laser_t),
        .NUM_ENTRIES (invaders_pkg::NUM_LASERS)
    ) i_las_pick (
        .hit     (las_hit),
        .entries (lasers),
        .any_hit (las_any),
        .chosen  (las_pick)
    );

    // invaders over cannon over lasers
    always_ff @(posedge clk25M) begin
        if (reset || !write_en) begin
            vdin <= '0;
        end else if (inv_any) begin
            vdin <= inv_pick.color;
        end else if (cannon_hit) begin
            vdin <= invaders_pkg::CANNON_COLOR;
        end else if (las_any) begin
            vdin <= las_pick.color;
        end else begin
            vdin <= '0;
        end
    end

endmodule

//--- rtl/slot_counter.sv
`timescale 1ns/100ps

module slot_counter (
    input  logic                 clk25M,
    input  logic                 reset,
    input  invaders_pkg::phase_t phase,
    output invaders_pkg::slot_t  slot,
    output logic                 last_slot
);

    // back to 0 whenever the phase advances
    always_ff @(posedge clk25M) begin
        if (reset || phase == invaders_pkg::PH_IDLE || last_slot) begin
            slot <= '0;
        end else begin
            slot <= slot + 1'b1;
        end
    end

    always_comb begin
        case (phase)
            invaders_pkg::PH_SCAN,
            invaders_pkg::PH_MOVE:
                last_slot = (slot == invaders_pkg::slot_t'(invaders_pkg::NUM_INVADERS - 1));
            invaders_pkg::PH_CANNON:
                last_slot = (slot == '0);
            invaders_pkg::PH_LASERS:
                last_slot = (slot == invaders_pkg::slot_t'(invaders_pkg::NUM_LASERS - 1));
            default:
                last_slot = 1'b0;
        endcase
    end

endmodule

//--- rtl/space_game_top.sv
`timescale 1ns/100ps

module space_game_top (
    input  logic                 clk25M,
    input  logic                 reset,
    input  logic                 frame_tick,
    input  logic                 march_en,
    input  logic [3:0]           speed,
    input  logic                 btn_left,
    input  logic                 btn_right,
    input  logic                 btn_fire,
    input  invaders_pkg::coord_t whpos,
    input  invaders_pkg::coord_t wvpos,
    input  logic [18:0]          write_addr_in,
    input  logic                 write_en,
    output logic [18:0]          write_addr_out,
    output logic                 write_en_out,
    output invaders_pkg::color_t vdin,
    output logic                 update_busy
);

    invaders_pkg::phase_t   phase;
    invaders_pkg::dir_t     dir;
    logic                   move_en;
    invaders_pkg::slot_t    slot;
    logic                   last_slot;
    logic                   edge_hit;
    invaders_pkg::invader_t invaders [invaders_pkg::NUM_INVADERS];
    invaders_pkg::coord_t   cannon_h;
    invaders_pkg::laser_t   lasers [invaders_pkg::NUM_LASERS];

    march_fsm i_march (
        .clk25M      (clk25M),
        .reset       (reset),
        .frame_tick  (frame_tick),
        .march_en    (march_en),
        .last_slot   (last_slot),
        .edge_hit    (edge_hit),
        .phase       (phase),
        .dir         (dir),
        .move_en     (move_en),
        .update_busy (update_busy)
    );

    slot_counter i_slots (
        .clk25M    (clk25M),
        .reset     (reset),
        .phase     (phase),
        .slot      (slot),
        .last_slot (last_slot)
    );

    invader_table i_invaders (
        .clk25M   (clk25M),
        .reset    (reset),
        .phase    (phase),
        .dir      (dir),
        .move_en  (move_en),
        .slot     (slot),
        .speed    (speed),
        .edge_hit (edge_hit),
        .invaders (invaders)
    );

    cannon_lasers i_cannon (
        .clk25M    (clk25M),
        .reset     (reset),
        .phase     (phase),
        .slot      (slot),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .btn_fire  (btn_fire),
        .cannon_h  (cannon_h),
        .lasers    (lasers)
    );

    pixel_renderer i_render (
        .clk25M   (clk25M),
        .reset    (reset),
        .whpos    (whpos),
        .wvpos    (wvpos),
        .write_en (write_en),
        .invaders (invaders),
        .cannon_h (cannon_h),
        .lasers   (lasers),
        .vdin     (vdin)
    );

    // keeps address and strobe aligned with vdin
    always_ff @(posedge clk25M) begin
        write_addr_out <= write_addr_in;
        if (reset) begin
            write_en_out <= 1'b0;
        end else begin
            write_en_out <= write_en;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module space_game_tb \
    -Mdir obj_dir -o space_game_sim -f space_game_top.f &&
./obj_dir/space_game_sim | tee /dev/stderr | grep -F -q "Simulation finished: PASS" &&
echo "run passed" || { echo "run failed"; exit 1; }

//--- space_game_top.f
rtl/invaders_pkg.sv
rtl/march_fsm.sv
rtl/slot_counter.sv
rtl/invader_table.sv
rtl/cannon_lasers.sv
rtl/first_hit_select.sv
rtl/pixel_renderer.sv
rtl/space_game_top.sv
test/space_game_asserts.sv
test/space_game_tb.sv

//--- test/space_game_asserts.sv
`timescale 1ns/100ps

module space_game_asserts (
    input logic                 clk25M,
    input logic                 reset,
    input logic                 update_busy,
    input logic                 write_en,
    input logic [18:0]          write_addr_in,
    input logic [18:0]          write_addr_out,
    input logic                 write_en_out,
    input invaders_pkg::color_t vdin
);

    int busy_len;

    // cycles of the current update so far
    always_ff @(posedge clk25M) begin
        if (reset || !update_busy) begin
            busy_len <= 0;
        end else begin
            busy_len <= busy_len + 1;
        end
    end

    busy_bounded: assert property (@(posedge clk25M) disable iff (reset)
        update_busy |-> busy_len < invaders_pkg::UPDATE_CYCLES)
        else $error("update_busy high longer than one update");

    busy_full: assert property (@(posedge clk25M) disable iff (reset)
        $fell(update_busy) |-> busy_len == invaders_pkg::UPDATE_CYCLES)
        else $error("update_busy ended early");

    en_delay: assert property (@(posedge clk25M) disable iff (reset)
        write_en_out == $past(write_en))
        else $error("write_en_out not one cycle behind write_en");

    addr_delay: assert property (@(posedge clk25M) disable iff (reset)
        write_addr_out == $past(write_addr_in))
        else $error("write_addr_out not one cycle behind write_addr_in");

    vdin_quiet: assert property (@(posedge clk25M) disable iff (reset)
        !write_en_out |-> vdin == '0)
        else $error("vdin nonzero without write strobe");

endmodule

//--- test/space_game_tb.sv
`timescale 1ns/100ps

module space_game_tb;

    localparam int TIMEOUT_CYCLES = 100;

    // probe kinds
    localparam logic [2:0] K_INV    = 3'd0;
    localparam logic [2:0] K_LEDGE  = 3'd1;
    localparam logic [2:0] K_TEDGE  = 3'd2;
    localparam logic [2:0] K_CANNON = 3'd3;
    localparam logic [2:0] K_LASER  = 3'd4;
    localparam logic [2:0] K_POINT  = 3'd5;

    typedef struct packed {
        logic        left;
        logic        right;
        logic        fire;
        logic        march;
        logic [3:0]  speed;
        logic [9:0]  frames;
        logic [2:0]  kind;
        logic [2:0]  idx;
        logic        we;
        logic [11:0] px;
        logic [11:0] py;
    } test_row_t;

    logic                 clk25M = 1'b0;
    logic                 reset;
    logic                 frame_tick;
    logic                 march_en;
    logic [3:0]           speed;
    logic                 btn_left;
    logic                 btn_right;
    logic                 btn_fire;
    invaders_pkg::coord_t whpos;
    invaders_pkg::coord_t wvpos;
    logic [18:0]          write_addr_in;
    logic                 write_en;
    logic [18:0]          write_addr_out;
    logic                 write_en_out;
    invaders_pkg::color_t vdin;
    logic                 update_busy;

    test_row_t tests [$];
    int        errors = 0;
    int        checks = 0;
    int        failed = 0;
    bit        timed_out = 1'b0;
    logic [31:0] lfsr = 32'hef99;

    // reference state
    int                   m_inv_h [invaders_pkg::NUM_INVADERS];
    int                   m_inv_v [invaders_pkg::NUM_INVADERS];
    bit                   m_alive [invaders_pkg::NUM_INVADERS];
    invaders_pkg::color_t m_inv_c [invaders_pkg::NUM_INVADERS];
    invaders_pkg::dir_t   m_dir;
    invaders_pkg::dir_t   m_last_h;
    int                   m_can_h;
    bit                   m_las_act [invaders_pkg::NUM_LASERS];
    int                   m_las_v [invaders_pkg::NUM_LASERS];
    int                   m_las_h [invaders_pkg::NUM_LASERS];

    always #20 clk25M = ~clk25M;

    space_game_top i_dut (
        .clk25M         (clk25M),
        .reset          (reset),
        .frame_tick     (frame_tick),
        .march_en       (march_en),
        .speed          (speed),
        .btn_left       (btn_left),
        .btn_right      (btn_right),
        .btn_fire       (btn_fire),
        .whpos          (whpos),
        .wvpos          (wvpos),
        .write_addr_in  (write_addr_in),
        .write_en       (write_en),
        .write_addr_out (write_addr_out),
        .write_en_out   (write_en_out),
        .vdin           (vdin),
        .update_busy    (update_busy)
    );

    bind space_game_top space_game_asserts i_asserts (
        .clk25M         (clk25M),
        .reset          (reset),
        .update_busy    (update_busy),
        .write_en       (write_en),
        .write_addr_in  (write_addr_in),
        .write_addr_out (write_addr_out),
        .write_en_out   (write_en_out),
        .vdin           (vdin)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic add_row(input int l, input int r, input int f, input int m, input int spd,
                           input int n, input logic [2:0] k, input int idx, input int we,
                           input int px, input int py);
        tests.push_back('{1'(l), 1'(r), 1'(f), 1'(m), 4'(spd), 10'(n), k, 3'(idx), 1'(we),
                          12'(px), 12'(py)});
    endtask

    task automatic build_table();
        // one probe inside every invader after reset
        for (int i = 0; i < invaders_pkg::NUM_INVADERS; i++) begin
            add_row(0, 0, 0, 0, 0, 0, K_INV, i, 1, 0, 0);
        end
        add_row(0, 0, 0, 0, 0, 0, K_CANNON, 0, 1, 0, 0);
        add_row(0, 0, 0, 0, 0, 0, K_POINT, 0, 1, 10, 200);
        add_row(0, 0, 0, 0, 0, 0, K_INV, 2, 0, 0, 0);
        // lasers, then one overlapping invader 7
        add_row(0, 0, 1, 0, 0, 1, K_LASER, 0, 1, 0, 0);
        add_row(0, 0, 0, 0, 0, 1, K_LASER, 0, 1, 0, 0);
        add_row(0, 0, 0, 0, 0, 84, K_POINT, 0, 1, 320, 88);
        add_row(0, 0, 1, 0, 0, 4, K_LASER, 3, 1, 0, 0);
        add_row(0, 0, 1, 0, 0, 1, K_POINT, 0, 1, 320, 447);
        // cannon to both edges
        add_row(1, 0, 0, 0, 0, 5, K_CANNON, 0, 1, 0, 0);
        add_row(1, 0, 0, 0, 0, 160, K_POINT, 0, 1, 0, 460);
        add_row(1, 0, 0, 0, 0, 3, K_POINT, 0, 1, 32, 460);
        add_row(0, 1, 0, 0, 0, 310, K_POINT, 0, 1, 639, 460);
        add_row(0, 1, 0, 0, 0, 2, K_POINT, 0, 1, 607, 460);
        // march
        add_row(0, 0, 0, 1, 5, 1, K_LEDGE, 0, 1, 0, 0);
        add_row(0, 0, 0, 1, 5, 1, K_LEDGE, 6, 1, 0, 0);
        add_row(0, 0, 0, 1, 15, 18, K_LEDGE, 3, 1, 0, 0);
        add_row(0, 0, 0, 1, 15, 1, K_LEDGE, 3, 1, 0, 0);
        add_row(0, 0, 0, 1, 15, 1, K_TEDGE, 7, 1, 0, 0);
        add_row(0, 0, 0, 1, 15, 2, K_LEDGE, 4, 1, 0, 0);
        add_row(0, 0, 0, 0, 15, 3, K_LEDGE, 1, 1, 0, 0);
    endtask

    task automatic model_reset();
        for (int i = 0; i < invaders_pkg::NUM_INVADERS; i++) begin
            m_inv_h[i] = int'(invaders_pkg::INVADER_INIT[i].hpos);
            m_inv_v[i] = int'(invaders_pkg::INVADER_INIT[i].vpos);
            m_alive[i] = invaders_pkg::INVADER_INIT[i].alive;
            m_inv_c[i] = invaders_pkg::INVADER_INIT[i].color;
        end
        for (int i = 0; i < invaders_pkg::NUM_LASERS; i++) begin
            m_las_act[i] = 1'b0;
        end
        m_dir    = invaders_pkg::DIR_RIGHT;
        m_last_h = invaders_pkg::DIR_RIGHT;
        m_can_h  = invaders_pkg::CANNON_INIT_H;
    endtask

    task automatic model_frame(input logic march, input int spd, input logic l, input logic r,
                               input logic f);
        bit edge_seen;
        int spawn_slot;
        edge_seen = 1'b0;
        for (int i = 0; i < invaders_pkg::NUM_INVADERS; i++) begin
            if (m_alive[i] && m_dir == invaders_pkg::DIR_RIGHT &&
                m_inv_h[i] + invaders_pkg::INVADER_SIZE + spd > invaders_pkg::FIELD_WIDTH)
                edge_seen = 1'b1;
            if (m_alive[i] && m_dir == invaders_pkg::DIR_LEFT && m_inv_h[i] < spd)
                edge_seen = 1'b1;
        end
        if (march) begin
            if (m_dir == invaders_pkg::DIR_DOWN) begin
                for (int i = 0; i < invaders_pkg::NUM_INVADERS; i++) begin
                    if (m_alive[i]) m_inv_v[i] += invaders_pkg::DOWN_STEP;
                end
                m_dir = (m_last_h == invaders_pkg::DIR_RIGHT) ? invaders_pkg::DIR_LEFT
                                                              : invaders_pkg::DIR_RIGHT;
            end else if (edge_seen) begin
                m_last_h = m_dir;
                m_dir    = invaders_pkg::DIR_DOWN;
            end else begin
                for (int i = 0; i < invaders_pkg::NUM_INVADERS; i++) begin
                    if (m_alive[i])
                        m_inv_h[i] += (m_dir == invaders_pkg::DIR_RIGHT) ? spd : -spd;
                end
            end
        end
        if (l && m_can_h >= invaders_pkg::CANNON_STEP)
            m_can_h -= invaders_pkg::CANNON_STEP;
        else if (r && m_can_h + invaders_pkg::CANNON_SIZE + invaders_pkg::CANNON_STEP <=
                 invaders_pkg::FIELD_WIDTH)
            m_can_h += invaders_pkg::CANNON_STEP;
        spawn_slot = -1;
        for (int i = 0; i < invaders_pkg::NUM_LASERS; i++) begin
            if (!m_las_act[i] && spawn_slot < 0) spawn_slot = i;
        end
        for (int i = 0; i < invaders_pkg::NUM_LASERS; i++) begin
            if (m_las_act[i] && m_las_v[i] >= invaders_pkg::LASER_STEP)
                m_las_v[i] -= invaders_pkg::LASER_STEP;
            else
                m_las_act[i] = 1'b0;
        end
        if (f && spawn_slot >= 0) begin
            m_las_act[spawn_slot] = 1'b1;
            m_las_v[spawn_slot]   = invaders_pkg::CANNON_V - invaders_pkg::LASER_LEN;
            m_las_h[spawn_slot]   = m_can_h + invaders_pkg::LASER_OFFSET_H;
        end
    endtask

    // invaders, then cannon, then lasers
    function automatic invaders_pkg::color_t model_color(int h, int v);
        for (int i = 0; i < invaders_pkg::NUM_INVADERS; i++) begin
            if (m_alive[i] && h >= m_inv_h[i] && h < m_inv_h[i] + invaders_pkg::INVADER_SIZE &&
                v >= m_inv_v[i] && v < m_inv_v[i] + invaders_pkg::INVADER_SIZE)
                return m_inv_c[i];
        end
        if (h >= m_can_h && h < m_can_h + invaders_pkg::CANNON_SIZE &&
            v >= invaders_pkg::CANNON_V && v < invaders_pkg::CANNON_V + invaders_pkg::CANNON_SIZE)
            return invaders_pkg::CANNON_COLOR;
        for (int i = 0; i < invaders_pkg::NUM_LASERS; i++) begin
            if (m_las_act[i] && h >= m_las_h[i] - 1 && h <= m_las_h[i] + 1 &&
                v >= m_las_v[i] && v < m_las_v[i] + invaders_pkg::LASER_LEN)
                return invaders_pkg::LASER_COLOR;
        end
        return 12'h000;
    endfunction

    task automatic check_color(input invaders_pkg::color_t got, input invaders_pkg::color_t exp,
                               input int h, input int v);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: vdin = %h, expected %h at (%0d, %0d)",
                     $time, got, exp, h, v);
        end
    endtask

    task automatic check_addr(input logic [18:0] got_addr, input logic got_en,
                              input logic [18:0] exp_addr, input logic exp_en);
        checks++;
        if (got_en !== exp_en) begin
            errors++;
            $display("Error at %0d ns: write_en_out = %b, expected %b", $time, got_en, exp_en);
        end
        if (got_addr !== exp_addr) begin
            errors++;
            $display("Error at %0d ns: write_addr_out = %h, expected %h",
                     $time, got_addr, exp_addr);
        end
    endtask

    task automatic run_frame();
        int n;
        @(posedge clk25M);
        #2 frame_tick = 1'b1;
        @(posedge clk25M);
        #2 frame_tick = 1'b0;
        n = 0;
        while (!update_busy && n < TIMEOUT_CYCLES) begin
            @(posedge clk25M);
            #1 n++;
        end
        if (!update_busy) begin
            timed_out = 1'b1;
            $display("timeout: update_busy never rose after frame_tick");
            return;
        end
        // busy must follow the sampled tick on the very next cycle
        if (n != 0) begin
            errors++;
            $display("update_busy rose %0d cycles late after frame_tick", n);
        end
        n = 0;
        while (update_busy && n < TIMEOUT_CYCLES) begin
            @(posedge clk25M);
            #1 n++;
        end
        if (update_busy) begin
            timed_out = 1'b1;
            $display("timeout: update_busy stayed high");
        end
    endtask

    task automatic probe_pixel(input int h, input int v, input logic we);
        int          a;
        logic [18:0] addr;
        rand_bits(19, a);
        addr = 19'(a);
        @(posedge clk25M);
        #2;
        whpos         = 12'(h);
        wvpos         = 12'(v);
        write_en      = we;
        write_addr_in = addr;
        @(posedge clk25M);
        #1;
        check_addr(write_addr_out, write_en_out, addr, we);
        check_color(vdin, we ? model_color(h, v) : 12'h000, h, v);
        #1 write_en = 1'b0;
    endtask

    task automatic probe_row(input test_row_t row);
        int i;
        int oh;
        int ov;
        i = int'(row.idx);
        rand_bits(5, oh);
        rand_bits(5, ov);
        case (row.kind)
            K_INV:
                probe_pixel(m_inv_h[i] + oh, m_inv_v[i] + ov, row.we);
            K_LEDGE: begin
                probe_pixel(m_inv_h[i] - 1, m_inv_v[i] + ov, row.we);
                probe_pixel(m_inv_h[i], m_inv_v[i] + ov, row.we);
            end
            K_TEDGE: begin
                probe_pixel(m_inv_h[i] + oh, m_inv_v[i] - 1, row.we);
                probe_pixel(m_inv_h[i] + oh, m_inv_v[i], row.we);
            end
            K_CANNON:
                probe_pixel(m_can_h + oh, invaders_pkg::CANNON_V + ov, row.we);
            K_LASER:
                probe_pixel(m_las_h[i] - 1 + oh % 3, m_las_v[i] + ov % invaders_pkg::LASER_LEN,
                            row.we);
            default:
                probe_pixel(int'(row.px), int'(row.py), row.we);
        endcase
    endtask

    initial begin
        test_row_t row;
        int        err0;
        reset         = 1'b1;
        frame_tick    = 1'b0;
        march_en      = 1'b0;
        speed         = 4'd0;
        btn_left      = 1'b0;
        btn_right     = 1'b0;
        btn_fire      = 1'b0;
        whpos         = '0;
        wvpos         = '0;
        write_addr_in = '0;
        write_en      = 1'b0;
        build_table();
        model_reset();
        repeat (16) @(posedge clk25M);
        #2 reset = 1'b0;

        for (int t = 0; t < tests.size() && !timed_out; t++) begin
            row  = tests[t];
            err0 = errors;
            @(posedge clk25M);
            #2;
            btn_left  = row.left;
            btn_right = row.right;
            btn_fire  = row.fire;
            march_en  = row.march;
            speed     = row.speed;
            for (int f = 0; f < int'(row.frames) && !timed_out; f++) begin
                run_frame();
                model_frame(row.march, int'(row.speed), row.left, row.right, row.fire);
            end
            if (!timed_out) probe_row(row);
            if (errors != err0 || timed_out) failed++;
            $display("test %0d: %s", t, (errors != err0 || timed_out) ? "mismatch" : "ok");
        end

        $display("%0d tests, %0d failed, %0d checks, %0d errors", tests.size(), failed,
                 checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
